/* hdl/prog_pkg.sv */
package prog_pkg;

  // iccm geometry
  localparam int unsigned ADDR_W = 10;
  localparam int unsigned DATA_W = 32;

  // bit period divisor width
  localparam int unsigned BAUD_W = 16;

  // program terminator, never stored
  localparam logic [DATA_W-1:0] END_WORD = 32'h0000_0FFF;

  typedef enum logic [1:0] {
    BOOT,
    LOAD,
    DONE
  } loader_state_e;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } iccm_wr_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } fetch_rsp_t;

endpackage

/* hdl/uart_rx_prog.sv */
`timescale 1ns/10ps

module uart_rx_prog (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [prog_pkg::BAUD_W-1:0]   clks_per_bit_i,
  input  logic                          rx_i,
  output prog_pkg::rx_byte_t            rx_byte_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                    state_q;
  logic [1:0]                   rx_sync_q;
  logic [prog_pkg::BAUD_W-1:0]  cnt_q;
  logic [prog_pkg::BAUD_W-1:0]  half_bit;
  logic [prog_pkg::BAUD_W-1:0]  last_cnt;
  logic [2:0]                   bit_idx_q;
  logic [7:0]                   shift_q;
  logic                         valid_q;
  logic                         rx_s;

  assign rx_s     = rx_sync_q[1];
  assign half_bit = clks_per_bit_i >> 1;
  assign last_cnt = clks_per_bit_i - 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // idle line is high
      rx_sync_q <= 2'b11;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
      valid_q   <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // glitch check at mid start bit
          if (cnt_q == half_bit) begin
            cnt_q   <= '0;
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == last_cnt) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          // framing error drops the byte
          if (cnt_q == last_cnt) begin
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && cnt_q == last_cnt) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid = valid_q;
  assign rx_byte_o.data  = shift_q;

endmodule

/* hdl/iccm_controller.sv */
`timescale 1ns/10ps

module iccm_controller (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  prog_i,
  input  prog_pkg::rx_byte_t    rx_byte_i,
  output prog_pkg::iccm_wr_t    iccm_wr_o,
  output logic                  prog_rst_n_o,
  output logic                  prog_active_o
);

  prog_pkg::loader_state_e        state_q;
  logic [1:0]                     byte_cnt_q;
  logic [prog_pkg::DATA_W-1:0]    word_q;
  logic [prog_pkg::DATA_W-1:0]    word_next;
  logic [prog_pkg::ADDR_W-1:0]    addr_q;
  logic                           we_q;
  logic                           prog_rst_n_q;
  logic                           byte_take;

  // msb first, new byte lands in the low lane
  assign word_next = {word_q[prog_pkg::DATA_W-9:0], rx_byte_i.data};
  assign byte_take = (state_q == prog_pkg::LOAD) && rx_byte_i.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= prog_pkg::BOOT;
      byte_cnt_q   <= '0;
      addr_q       <= '0;
      we_q         <= 1'b0;
      prog_rst_n_q <= 1'b0;
    end else begin
      we_q <= 1'b0;
      // advance once the write pulse has been seen
      if (we_q) begin
        addr_q <= addr_q + 1'b1;
      end
      case (state_q)
        prog_pkg::BOOT: begin
          if (prog_i) begin
            state_q <= prog_pkg::LOAD;
          end else begin
            state_q      <= prog_pkg::DONE;
            prog_rst_n_q <= 1'b1;
          end
        end
        prog_pkg::LOAD: begin
          if (byte_take) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              if (word_next == prog_pkg::END_WORD) begin
                // terminator, let the core run
                state_q      <= prog_pkg::DONE;
                prog_rst_n_q <= 1'b1;
              end else begin
                we_q <= 1'b1;
              end
            end
          end
        end
        prog_pkg::DONE: begin
          // held until the next reset
          state_q <= prog_pkg::DONE;
        end
        default: state_q <= prog_pkg::BOOT;
      endcase
    end
  end

  // word assembly
  always_ff @(posedge clk_i) begin
    if (byte_take) begin
      word_q <= word_next;
    end
  end

  assign iccm_wr_o.we    = we_q;
  assign iccm_wr_o.addr  = addr_q;
  assign iccm_wr_o.wdata = word_q;

  assign prog_rst_n_o  = prog_rst_n_q;
  assign prog_active_o = (state_q == prog_pkg::LOAD);

endmodule

/* hdl/rst_ctrl.sv */
`timescale 1ns/10ps

module rst_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic prog_rst_n_i,
  input  logic ndm_reset_i,
  output logic sys_rst_n_o
);

  logic       clr_n;
  logic [1:0] sync_q;

  // any source pulls the system reset at once
  assign clr_n = arst_n_i & prog_rst_n_i & ~ndm_reset_i;

  // release is delayed two edges
  always_ff @(posedge clk_i or negedge clr_n) begin
    if (!clr_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_n_o = sync_q[1];

endmodule

/* hdl/iccm_adapter.sv */
`timescale 1ns/10ps

module iccm_adapter (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          sys_rst_n_i,
  input  prog_pkg::iccm_wr_t            iccm_wr_i,
  input  prog_pkg::fetch_req_t          fetch_req_i,
  input  logic [prog_pkg::DATA_W-1:0]   sram_rdata_i,
  output prog_pkg::fetch_rsp_t          fetch_rsp_o,
  output logic                          sram_cs_o,
  output logic                          sram_we_o,
  output logic [prog_pkg::DATA_W/8-1:0] sram_wmask_o,
  output logic [prog_pkg::ADDR_W-1:0]   sram_addr_o,
  output logic [prog_pkg::DATA_W-1:0]   sram_wdata_o
);

  logic core_mode;
  logic rsp_valid_q;

  // core owns the port once the system is out of reset
  assign core_mode = sys_rst_n_i;

  assign sram_cs_o    = core_mode ? fetch_req_i.req : iccm_wr_i.we;
  assign sram_we_o    = ~core_mode & iccm_wr_i.we;
  assign sram_wmask_o = {(prog_pkg::DATA_W/8){~core_mode}};
  assign sram_addr_o  = core_mode ? fetch_req_i.addr : iccm_wr_i.addr;
  assign sram_wdata_o = iccm_wr_i.wdata;

  // one cycle read latency
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= core_mode & fetch_req_i.req;
    end
  end

  assign fetch_rsp_o.valid = rsp_valid_q;
  assign fetch_rsp_o.rdata = sram_rdata_i;

endmodule

/* hdl/sram_1rw.sv */
`timescale 1ns/10ps

module sram_1rw (
  input  logic                          clk_i,
  input  logic                          cs_i,
  input  logic                          we_i,
  input  logic [prog_pkg::DATA_W/8-1:0] wmask_i,
  input  logic [prog_pkg::ADDR_W-1:0]   addr_i,
  input  logic [prog_pkg::DATA_W-1:0]   wdata_i,
  output logic [prog_pkg::DATA_W-1:0]   rdata_o
);

  logic [prog_pkg::DATA_W-1:0] mem_q [2**prog_pkg::ADDR_W];
  logic [prog_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      if (we_i) begin
        // byte lanes
        for (int b = 0; b < prog_pkg::DATA_W/8; b++) begin
          if (wmask_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hdl/prog_loader_top.sv */
`timescale 1ns/10ps

module prog_loader_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          prog_i,
  input  logic [prog_pkg::BAUD_W-1:0]   clks_per_bit_i,
  input  logic                          uart_rx_i,
  input  logic                          ndm_reset_i,
  input  prog_pkg::fetch_req_t          fetch_req_i,
  output prog_pkg::fetch_rsp_t          fetch_rsp_o,
  output logic                          sys_rst_n_o,
  output logic                          prog_active_o
);

  prog_pkg::rx_byte_t            rx_byte;
  prog_pkg::iccm_wr_t            iccm_wr;
  logic                          prog_rst_n;

  // instruction sram port
  logic                          sram_cs;
  logic                          sram_we;
  logic [prog_pkg::DATA_W/8-1:0] sram_wmask;
  logic [prog_pkg::ADDR_W-1:0]   sram_addr;
  logic [prog_pkg::DATA_W-1:0]   sram_wdata;
  logic [prog_pkg::DATA_W-1:0]   sram_rdata;

  uart_rx_prog u_uart_rx_prog (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .clks_per_bit_i (clks_per_bit_i),
    .rx_i           (uart_rx_i),
    .rx_byte_o      (rx_byte)
  );

  iccm_controller u_iccm_controller (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .prog_i        (prog_i),
    .rx_byte_i     (rx_byte),
    .iccm_wr_o     (iccm_wr),
    .prog_rst_n_o  (prog_rst_n),
    .prog_active_o (prog_active_o)
  );

  rst_ctrl u_rst_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .prog_rst_n_i (prog_rst_n),
    .ndm_reset_i  (ndm_reset_i),
    .sys_rst_n_o  (sys_rst_n_o)
  );

  iccm_adapter u_iccm_adapter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sys_rst_n_i  (sys_rst_n_o),
    .iccm_wr_i    (iccm_wr),
    .fetch_req_i  (fetch_req_i),
    .sram_rdata_i (sram_rdata),
    .fetch_rsp_o  (fetch_rsp_o),
    .sram_cs_o    (sram_cs),
    .sram_we_o    (sram_we),
    .sram_wmask_o (sram_wmask),
    .sram_addr_o  (sram_addr),
    .sram_wdata_o (sram_wdata)
  );

  sram_1rw u_iccm (
    .clk_i   (clk_i),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .wmask_i (sram_wmask),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

endmodule

/* bench/prog_loader_props.sv */
`timescale 1ns/10ps

module prog_loader_props (
  input logic clk_i,
  input logic arst_n_i,
  input logic sys_rst_n_i,
  input logic prog_rst_n_i,
  input logic sram_we_i,
  input logic req_i,
  input logic rsp_valid_i
);

  int assert_fails = 0;

  // loader owns the sram only while the core is held
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sram_we_i |-> !sys_rst_n_i)
    else begin
      $error("sram write while the system reset is released");
      assert_fails++;
    end

  // fixed one cycle fetch latency
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (sys_rst_n_i && req_i) |=> rsp_valid_i)
    else begin
      $error("accepted fetch gave no response one cycle later");
      assert_fails++;
    end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(sys_rst_n_i && req_i) |=> !rsp_valid_i)
    else begin
      $error("fetch response without an accepted request");
      assert_fails++;
    end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !prog_rst_n_i |-> !sys_rst_n_i)
    else begin
      $error("system reset released while program reset is low");
      assert_fails++;
    end

endmodule

/* bench/tb_prog_loader.sv */
`timescale 1ns/10ps

module tb_prog_loader;

  localparam int TD_DEPTH   = 64;
  localparam int WAIT_LIMIT = 1000;

  logic                        clk;
  logic                        arst_n;
  logic                        prog;
  logic [prog_pkg::BAUD_W-1:0] clks_per_bit;
  logic                        uart_rx;
  logic                        ndm_reset;
  prog_pkg::fetch_req_t        fetch_req;
  prog_pkg::fetch_rsp_t        fetch_rsp;
  logic                        sys_rst_n;
  logic                        prog_active;

  // phase records from the data file and the expected iccm image
  logic [31:0] td [TD_DEPTH];
  logic [31:0] exp_mem [2**prog_pkg::ADDR_W];
  logic [31:0] lfsr;
  int          idx;
  int          exp_cnt;
  int          checks;
  int          errors;

  prog_loader_top dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .prog_i         (prog),
    .clks_per_bit_i (clks_per_bit),
    .uart_rx_i      (uart_rx),
    .ndm_reset_i    (ndm_reset),
    .fetch_req_i    (fetch_req),
    .fetch_rsp_o    (fetch_rsp),
    .sys_rst_n_o    (sys_rst_n),
    .prog_active_o  (prog_active)
  );

  bind iccm_adapter prog_loader_props u_adapter_props (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sys_rst_n_i  (sys_rst_n_i),
    .prog_rst_n_i (1'b1),
    .sram_we_i    (sram_we_o),
    .req_i        (fetch_req_i.req),
    .rsp_valid_i  (fetch_rsp_o.valid)
  );

  bind rst_ctrl prog_loader_props u_rst_props (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sys_rst_n_i  (sys_rst_n_o),
    .prog_rst_n_i (prog_rst_n_i),
    .sram_we_i    (1'b0),
    .req_i        (1'b0),
    .rsp_valid_i  (1'b0)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic send_bit(input logic b);
    @(posedge clk);
    uart_rx <= b;
    repeat (clks_per_bit - 1) @(posedge clk);
  endtask

  // 0 to 3 idle bits between frames
  task automatic idle_gap();
    int n;
    n = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      n = n * 2 + lfsr[0];
    end
    repeat (n * clks_per_bit) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      send_bit(b[i]);
    end
    send_bit(1'b1);
    idle_gap();
  endtask

  // most significant byte first
  task automatic send_word(input logic [31:0] w);
    for (int k = 3; k >= 0; k--) begin
      send_byte(w[k*8 +: 8]);
    end
  endtask

  task automatic wait_sys_rst(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (sys_rst_n !== level && n < WAIT_LIMIT);
    if (sys_rst_n !== level) begin
      errors++;
      $display("timeout: system reset did not go %s", level ? "high" : "low");
    end
  endtask

  task automatic wait_active();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (prog_active !== 1'b1 && n < WAIT_LIMIT);
    if (prog_active !== 1'b1) begin
      errors++;
      $display("timeout: loader never became active");
    end
  endtask

  // issue n back to back reads and match responses in order
  task automatic fetch_burst(input int base, input int n);
    int sent;
    int got;
    int cycles;
    int k;
    sent   = 0;
    got    = 0;
    cycles = 0;
    while (got < n && cycles < n + WAIT_LIMIT) begin
      @(posedge clk);
      k = base + sent;
      fetch_req.req  <= (sent < n);
      fetch_req.addr <= k[prog_pkg::ADDR_W-1:0];
      if (sent < n) begin
        sent++;
      end
      @(negedge clk);
      cycles++;
      if (fetch_rsp.valid) begin
        k = base + got;
        check_val(fetch_rsp.rdata, exp_mem[k[prog_pkg::ADDR_W-1:0]], "fetch data");
        check_val(cycles, got + 2, "fetch response cycle");
        got++;
      end
    end
    if (got < n) begin
      errors++;
      $display("timeout: %0d of %0d fetch responses never arrived", n - got, n);
    end
    @(posedge clk);
    fetch_req.req <= 1'b0;
  endtask

  task automatic run_phase();
    int   n;
    logic do_ndm;
    n      = 0;
    do_ndm = td[idx+2][0];
    @(posedge clk);
    arst_n       <= 1'b0;
    clks_per_bit <= td[idx][prog_pkg::BAUD_W-1:0];
    prog         <= td[idx+1][0];
    idx += 3;
    repeat (8) begin
      @(negedge clk);
      check_val(32'(sys_rst_n), 0, "system reset during reset");
      check_val(32'(fetch_rsp.valid), 0, "fetch valid during reset");
      check_val(32'(prog_active), 0, "loader active during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_val(32'(sys_rst_n), 0, "system reset right after reset");
    if (prog) begin
      wait_active();
      while (td[idx] != prog_pkg::END_WORD) begin
        send_word(td[idx]);
        exp_mem[n] = td[idx];
        n++;
        idx++;
        @(negedge clk);
        check_val(32'(sys_rst_n), 0, "system reset while loading");
        check_val(32'(prog_active), 1, "loader active while loading");
      end
      send_word(prog_pkg::END_WORD);
      if (n > exp_cnt) begin
        exp_cnt = n;
      end
    end else begin
      // boot without a download, words are not sent
      while (td[idx] != prog_pkg::END_WORD) begin
        idx++;
      end
    end
    idx++;
    wait_sys_rst(1'b1);
    check_val(32'(prog_active), 0, "loader active after release");
    fetch_burst(0, exp_cnt);
    if (exp_cnt > 0) begin
      fetch_burst(exp_cnt - 1, 1);
    end
    if (do_ndm) begin
      @(posedge clk);
      ndm_reset <= 1'b1;
      wait_sys_rst(1'b0);
      repeat (4) begin
        @(posedge clk);
        fetch_req.req  <= 1'b1;
        fetch_req.addr <= '0;
        @(negedge clk);
        check_val(32'(fetch_rsp.valid), 0, "fetch valid during ndm reset");
      end
      @(posedge clk);
      fetch_req.req <= 1'b0;
      ndm_reset     <= 1'b0;
      wait_sys_rst(1'b1);
      fetch_burst(0, exp_cnt);
    end
  endtask

  initial begin
    arst_n       = 1'b0;
    prog         = 1'b0;
    clks_per_bit = 16'd16;
    uart_rx      = 1'b1;
    ndm_reset    = 1'b0;
    fetch_req    = '0;
    lfsr         = 32'he5d5_4249;
    idx          = 0;
    exp_cnt      = 0;
    checks       = 0;
    errors       = 0;
    $readmemh("bench/prog_loader_testdata.txt", td);
    // a zero bit period closes the record list
    while (idx < TD_DEPTH - 3 && td[idx] != 32'h0) begin
      run_phase();
    end
    errors += dut.u_iccm_adapter.u_adapter_props.assert_fails;
    errors += dut.u_rst_ctrl.u_rst_props.assert_fails;
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* bench/prog_loader_testdata.txt */
// one hex value per line, records of: bit period, prog_i, ndm pulse flag,
// then program words closed by 00000fff; a bit period of 0 ends the file
00000010
00000001
00000000
13579bdf
deadbeef
00a00093
0ff00113
40208033
00000fff
0000000c
00000001
00000000
cafe0001
cafe0002
00000fff
00000010
00000000
00000000
00000fff
00000010
00000000
00000001
00000fff
00000000

/* prog_loader.f */
hdl/prog_pkg.sv
hdl/uart_rx_prog.sv
hdl/iccm_controller.sv
hdl/rst_ctrl.sv
hdl/iccm_adapter.sv
hdl/sram_1rw.sv
hdl/prog_loader_top.sv
bench/prog_loader_props.sv
bench/tb_prog_loader.sv

/* Bender.yml */
package:
  name: prog_loader

sources:
  - hdl/prog_pkg.sv
  - hdl/uart_rx_prog.sv
  - hdl/iccm_controller.sv
  - hdl/rst_ctrl.sv
  - hdl/iccm_adapter.sv
  - hdl/sram_1rw.sv
  - hdl/prog_loader_top.sv
  - target: test
    files:
      - bench/prog_loader_props.sv
      - bench/tb_prog_loader.sv
